/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv32i_frontend
FLIST     ?= rv32i_frontend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FLIST)) src/rv32i_frontend_cfg.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rv32i_frontend.f */
+incdir+src
src/rv32i_frontend_pkg.sv
src/fetch_unit.sv
src/instruction_queue.sv
src/decode_stage.sv
src/rv32i_frontend.sv
sim/tb_rv32i_frontend.sv

/* sim/tb_rv32i_frontend.sv */
`timescale 1ns/1ps
`include "rv32i_frontend_cfg.svh"

module tb_rv32i_frontend;

    localparam logic [31:0] seed = 32'h53ca_057e;
    localparam int prog_words  = 64;     // the program table holds word addresses 0 to 63.
    localparam int item_target = 400;    // decoded items checked along the predicted path.
    localparam int run_limit   = 40000;  // cycles for the whole run.
    localparam int idle_limit  = 500;    // longest wait for a new request.
    localparam int ack_limit   = 20;     // longest wait for a request to drop after its ack.
    localparam int hold_cycles = 60;     // a back-end stall this long fills the queue.

    logic clk;
    logic rst_n;
    logic imem_req;
    logic [31:0] imem_addr;
    logic imem_ack;
    logic [31:0] imem_rdata;
    logic redirect_valid;
    logic [31:0] redirect_pc;
    logic dec_req;
    logic dec_ack;
    logic [31:0] dec_pc;
    logic [31:0] dec_pc_next;
    logic dec_pred;
    rv32i_frontend_pkg::opcode_e dec_opcode;
    logic [4:0] dec_rd;
    logic [4:0] dec_rs1;
    logic [4:0] dec_rs2;
    logic [31:0] dec_imm;

    logic [31:0] prog [prog_words];
    logic [31:0] lfsr = seed;
    int items_checked = 0;
    logic [31:0] ref_pc;                 // next pc expected on the predicted path.
    logic dec_req_q;
    logic redirect_q;
    logic imem_req_q;
    logic [31:0] imem_addr_q;
    logic [31:0] held_pc;
    logic [31:0] held_next;
    logic [31:0] held_imm;
    logic [19:0] held_misc;              // pred, opcode and the three register fields.

    rv32i_frontend rv32i_frontend_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;          // 40 ns period.
    end

    // fibonacci lfsr with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);      // one step for every bit taken.
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("ERR %0d ns %s expected %h actual %h", $time, name, expected, actual);
        $display("Test FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("%0d ns: %s", $time, what);
        $display("Test FAILED");
        $fatal(1, "stopped at the first protocol error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else value_error(name, expected, actual);
    endtask

    function automatic logic [31:0] imm_b(input logic [31:0] w);
        return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
    endfunction

    function automatic logic [31:0] imm_j(input logic [31:0] w);
        return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
    endfunction

    // the reference decoder takes the class from the major opcode.
    function automatic rv32i_frontend_pkg::opcode_e class_of(input logic [31:0] w);
        case (w[6:0])
            7'h37: return rv32i_frontend_pkg::OP_LUI;
            7'h17: return rv32i_frontend_pkg::OP_AUIPC;
            7'h6f: return rv32i_frontend_pkg::OP_JAL;
            7'h67: return rv32i_frontend_pkg::OP_JALR;
            7'h63: return rv32i_frontend_pkg::OP_BRANCH;
            7'h03: return rv32i_frontend_pkg::OP_LOAD;
            7'h23: return rv32i_frontend_pkg::OP_STORE;
            7'h13: return rv32i_frontend_pkg::OP_IMM;
            7'h33: return rv32i_frontend_pkg::OP_REG;
            7'h0f: return rv32i_frontend_pkg::OP_FENCE;
            7'h73: return rv32i_frontend_pkg::OP_SYSTEM;
            default: return rv32i_frontend_pkg::OP_ILLEGAL;
        endcase
    endfunction

    function automatic logic [31:0] imm_of(input logic [31:0] w);
        case (class_of(w))
            rv32i_frontend_pkg::OP_LUI, rv32i_frontend_pkg::OP_AUIPC: return {w[31:12], 12'h000};
            rv32i_frontend_pkg::OP_JAL:    return imm_j(w);
            rv32i_frontend_pkg::OP_BRANCH: return imm_b(w);
            rv32i_frontend_pkg::OP_STORE:  return 32'($signed({w[31:25], w[11:7]}));
            rv32i_frontend_pkg::OP_REG, rv32i_frontend_pkg::OP_ILLEGAL: return 32'h0;
            default: return 32'($signed(w[31:20]));  // the I format covers the rest.
        endcase
    endfunction

    // backward taken, forward not taken, jal always taken.
    function automatic logic predict_taken(input logic [31:0] w);
        logic [31:0] b;
        b = imm_b(w);
        return (class_of(w) == rv32i_frontend_pkg::OP_JAL) ||
               (class_of(w) == rv32i_frontend_pkg::OP_BRANCH && b[31]);
    endfunction

    function automatic logic [31:0] predict_next(input logic [31:0] pc, input logic [31:0] w);
        if (!predict_taken(w)) return pc + 32'd4;
        if (class_of(w) == rv32i_frontend_pkg::OP_JAL) return pc + imm_j(w);
        return pc + imm_b(w);
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] off, input logic [14:0] r);
        return {off[12], off[10:5], r[4:0], r[9:5], r[12:10], off[4:1], off[11], 7'h63};
    endfunction

    // every jump target stays inside the table, and the last word jumps back to 0.
    task automatic load_program();
        logic [31:0] k;
        logic [31:0] r;
        int target;
        for (int i = 0; i < prog_words; i++) begin
            k = rand_bits(4);
            r = rand_bits(25);
            target = int'(rand_bits(6));
            case (k[3:0])
                4'd0:       prog[i] = {r[24:0], 7'h37};
                4'd1:       prog[i] = {r[24:0], 7'h17};
                4'd2, 4'd3: prog[i] = enc_jal(r[4:0], 21'((target - i) * 4));
                4'd4:       prog[i] = {r[24:0], 7'h67};
                4'd6: begin
                    if (i > 0) prog[i] = enc_branch(13'(((target % i) - i) * 4), r[14:0]);
                    else prog[i] = enc_branch(13'd8, r[14:0]);
                end
                4'd7:       prog[i] = {r[24:0], 7'h03};
                4'd8:       prog[i] = {r[24:0], 7'h23};
                4'd9, 4'd10: prog[i] = {r[24:0], 7'h13};
                4'd11:      prog[i] = {r[24:0], 7'h33};
                4'd12:      prog[i] = {r[24:0], 7'h0f};
                4'd13:      prog[i] = {r[24:0], 7'h73};
                4'd14:      prog[i] = {r[24:0], 7'h7f};  // not an rv32i opcode.
                default:    prog[i] = enc_branch(13'((target % 32 + 1) * 4), r[14:0]);
            endcase
        end
        prog[prog_words-1] = enc_jal(5'd0, 21'(-(prog_words - 1) * 4));
    endtask

    // four-phase ordering on both handshakes.
    fetch_after_release: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(imem_req) |-> !$past(imem_ack))
        else report_failure("imem_req rose while the previous imem_ack was still high");
    fetch_drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(imem_req) |-> $past(imem_ack))
        else report_failure("imem_req fell before imem_ack was seen");
    offer_after_release: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dec_req) |-> !$past(dec_ack))
        else report_failure("dec_req rose while the previous dec_ack was still high");
    offer_drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(dec_req) |-> $past(dec_ack))
        else report_failure("dec_req fell before dec_ack was seen");

    // an item offered right after a redirect was popped in the flush cycle and is stale.
    always @(posedge clk) begin : scoreboard
        logic [31:0] word;
        if (!rst_n) begin
            ref_pc     = `FRONTEND_RESET_PC;
            dec_req_q  = 1'b0;
            redirect_q = 1'b0;
            imem_req_q = 1'b0;
        end else begin
            if (imem_req && imem_req_q) check_value("imem_addr", imem_addr_q, imem_addr);
            if (dec_req && !dec_req_q) begin
                if (!redirect_q) begin
                    check_value("dec_pc", ref_pc, dec_pc);   // no item lost or repeated.
                end
                assert (dec_pc < 32'(prog_words * 4))
                    else report_failure("dec_pc points outside the program table");
                word = prog[dec_pc[7:2]];
                check_value("dec_opcode", 32'(class_of(word)), 32'(dec_opcode));
                check_value("dec_rd", 32'(word[11:7]), 32'(dec_rd));
                check_value("dec_rs1", 32'(word[19:15]), 32'(dec_rs1));
                check_value("dec_rs2", 32'(word[24:20]), 32'(dec_rs2));
                check_value("dec_imm", imm_of(word), dec_imm);
                check_value("dec_pc_next", predict_next(dec_pc, word), dec_pc_next);
                check_value("dec_pred", 32'(predict_taken(word)), 32'(dec_pred));
                if (!redirect_q) begin
                    ref_pc = predict_next(ref_pc, word);
                    items_checked++;
                end
                held_pc   = dec_pc;
                held_next = dec_pc_next;
                held_imm  = dec_imm;
                held_misc = {dec_pred, dec_opcode, dec_rd, dec_rs1, dec_rs2};
            end else if (dec_req || dec_ack) begin
                check_value("dec_pc", held_pc, dec_pc);      // fields hold until dec_ack falls.
                check_value("dec_pc_next", held_next, dec_pc_next);
                check_value("dec_imm", held_imm, dec_imm);
                check_value("dec_pred/opcode/rd/rs1/rs2", 32'(held_misc),
                            32'({dec_pred, dec_opcode, dec_rd, dec_rs1, dec_rs2}));
            end
            if (redirect_valid) ref_pc = redirect_pc;     // the path restarts here.
            redirect_q  = redirect_valid;
            dec_req_q   = dec_req;
            imem_req_q  = imem_req;
            imem_addr_q = imem_addr;
        end
    end

    // the instruction memory answers each request after a random delay.
    initial begin : memory_model
        int waited;
        bit first;
        first = 1'b1;
        imem_ack = 1'b0;
        imem_rdata = '0;
        @(negedge clk);
        forever begin
            waited = 0;
            while (imem_req !== 1'b1) begin
                @(negedge clk);
                waited++;
                if (waited > idle_limit) report_failure("no instruction fetch request arrived");
            end
            if (first) check_value("imem_addr", `FRONTEND_RESET_PC, imem_addr);
            first = 1'b0;
            assert (imem_addr < 32'(prog_words * 4) && imem_addr[1:0] == 2'b00)
                else report_failure("fetch address is outside the program table");
            repeat (int'(rand_bits(2))) @(negedge clk);
            imem_rdata = prog[imem_addr[7:2]];
            imem_ack = 1'b1;
            waited = 0;
            while (imem_req !== 1'b0) begin
                @(negedge clk);
                waited++;
                if (waited > ack_limit) report_failure("imem_req stayed high after imem_ack");
            end
            repeat (int'(rand_bits(2))) @(negedge clk);
            imem_ack = 1'b0;
        end
    end

    // the back end sometimes stalls long enough to fill the queue.
    initial begin : backend_model
        int waited;
        int gap;
        dec_ack = 1'b0;
        @(negedge clk);
        forever begin
            waited = 0;
            while (dec_req !== 1'b1) begin
                @(negedge clk);
                waited++;
                if (waited > idle_limit) report_failure("no decoded item reached the back end");
            end
            gap = int'(rand_bits(2));
            if (rand_bits(4) == 0) gap = hold_cycles;
            repeat (gap) @(negedge clk);
            dec_ack = 1'b1;
            waited = 0;
            while (dec_req !== 1'b0) begin
                @(negedge clk);
                waited++;
                if (waited > ack_limit) report_failure("dec_req stayed high after dec_ack");
            end
            repeat (int'(rand_bits(2))) @(negedge clk);
            dec_ack = 1'b0;
        end
    end

    initial begin : stimulus
        int cycles;
        int quiet;
        logic [31:0] pick;
        rst_n = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc = '0;
        load_program();
        repeat (5) @(negedge clk);
        assert (imem_req === 1'b0 && dec_req === 1'b0)
            else report_failure("a request was active during reset");
        rst_n = 1'b1;
        cycles = 0;
        quiet = 0;
        while (items_checked < item_target) begin
            @(negedge clk);
            cycles++;
            quiet++;
            if (cycles > run_limit) report_failure("timed out before all items were checked");
            redirect_valid = 1'b0;
            if (quiet > 40 && rand_bits(5) == 0) begin
                pick = rand_bits(6);
                redirect_pc = pick << 2;             // any word of the table.
                redirect_valid = 1'b1;
                quiet = 0;
            end
        end
        @(negedge clk);
        redirect_valid = 1'b0;
        $display("Test OK");
        $finish;
    end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps

// pops one entry at a time, decodes it and offers it to the back end.
module decode_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          valid_out,
    input  rv32i_frontend_pkg::rv32i_word inst_out,
    input  rv32i_frontend_pkg::rv32i_word pc_out,
    input  rv32i_frontend_pkg::rv32i_word pc_next_out,
    input  logic                          pred_out,
    output logic                          pop,
    output logic                          dec_req,
    input  logic                          dec_ack,
    output rv32i_frontend_pkg::rv32i_word dec_pc,
    output rv32i_frontend_pkg::rv32i_word dec_pc_next,
    output logic                          dec_pred,
    output rv32i_frontend_pkg::opcode_e   dec_opcode,
    output logic [4:0]                    dec_rd,
    output logic [4:0]                    dec_rs1,
    output logic [4:0]                    dec_rs2,
    output rv32i_frontend_pkg::rv32i_word dec_imm
);

    rv32i_frontend_pkg::decode_state_e state;
    rv32i_frontend_pkg::opcode_e       op_class;
    rv32i_frontend_pkg::rv32i_word     imm;
    rv32i_frontend_pkg::rv32i_word     i_imm;
    rv32i_frontend_pkg::rv32i_word     s_imm;
    rv32i_frontend_pkg::rv32i_word     b_imm;
    rv32i_frontend_pkg::rv32i_word     u_imm;
    rv32i_frontend_pkg::rv32i_word     j_imm;

    // a new item is taken only when idle and the previous ack is gone.
    assign pop = (state == rv32i_frontend_pkg::DEC_IDLE) && valid_out && !dec_ack;

    // all immediate formats, sign-extended from bit 31.
    assign i_imm = {{20{inst_out[31]}}, inst_out[31:20]};
    assign s_imm = {{20{inst_out[31]}}, inst_out[31:25], inst_out[11:7]};
    assign b_imm = {{20{inst_out[31]}}, inst_out[7], inst_out[30:25], inst_out[11:8], 1'b0};
    assign u_imm = {inst_out[31:12], 12'h000};
    assign j_imm = {{12{inst_out[31]}}, inst_out[19:12], inst_out[20], inst_out[30:21], 1'b0};

    always_comb begin
        case (inst_out[6:0])                         // major opcode.
            7'b0110111: op_class = rv32i_frontend_pkg::OP_LUI;
            7'b0010111: op_class = rv32i_frontend_pkg::OP_AUIPC;
            7'b1101111: op_class = rv32i_frontend_pkg::OP_JAL;
            7'b1100111: op_class = rv32i_frontend_pkg::OP_JALR;
            7'b1100011: op_class = rv32i_frontend_pkg::OP_BRANCH;
            7'b0000011: op_class = rv32i_frontend_pkg::OP_LOAD;
            7'b0100011: op_class = rv32i_frontend_pkg::OP_STORE;
            7'b0010011: op_class = rv32i_frontend_pkg::OP_IMM;
            7'b0110011: op_class = rv32i_frontend_pkg::OP_REG;
            7'b0001111: op_class = rv32i_frontend_pkg::OP_FENCE;
            7'b1110011: op_class = rv32i_frontend_pkg::OP_SYSTEM;
            default:    op_class = rv32i_frontend_pkg::OP_ILLEGAL;
        endcase
    end

    // the class picks the immediate format.
    always_comb begin
        case (op_class)
            rv32i_frontend_pkg::OP_LUI,
            rv32i_frontend_pkg::OP_AUIPC:  imm = u_imm;
            rv32i_frontend_pkg::OP_JAL:    imm = j_imm;
            rv32i_frontend_pkg::OP_BRANCH: imm = b_imm;
            rv32i_frontend_pkg::OP_STORE:  imm = s_imm;
            rv32i_frontend_pkg::OP_JALR,
            rv32i_frontend_pkg::OP_LOAD,
            rv32i_frontend_pkg::OP_IMM,
            rv32i_frontend_pkg::OP_FENCE,
            rv32i_frontend_pkg::OP_SYSTEM: imm = i_imm;
            default:                       imm = '0;  // register ops and illegal words.
        endcase
    end

    // the result is loaded once on pop and holds through the handshake.
    always_ff @(posedge clk) begin
        if (pop) begin
            dec_pc      <= pc_out;
            dec_pc_next <= pc_next_out;
            dec_pred    <= pred_out;
            dec_opcode  <= op_class;
            dec_rd      <= inst_out[11:7];
            dec_rs1     <= inst_out[19:15];
            dec_rs2     <= inst_out[24:20];
            dec_imm     <= imm;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= rv32i_frontend_pkg::DEC_IDLE;
            dec_req <= 1'b0;
        end else begin
            case (state)
                rv32i_frontend_pkg::DEC_IDLE: begin
                    if (pop) begin
                        dec_req <= 1'b1;            // rises the cycle after the pop.
                        state   <= rv32i_frontend_pkg::DEC_WAIT_ACK;
                    end
                end
                rv32i_frontend_pkg::DEC_WAIT_ACK: begin
                    if (dec_ack) begin
                        dec_req <= 1'b0;
                        state   <= rv32i_frontend_pkg::DEC_WAIT_RELEASE;
                    end
                end
                rv32i_frontend_pkg::DEC_WAIT_RELEASE: begin
                    if (!dec_ack) begin
                        state <= rv32i_frontend_pkg::DEC_IDLE;
                    end
                end
                default: state <= rv32i_frontend_pkg::DEC_IDLE;
            endcase
        end
    end

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps
`include "rv32i_frontend_cfg.svh"

// fetches one word at a time over a four-phase req/ack handshake.
// every word gets a static prediction (backward taken, forward not taken).
module fetch_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic                          imem_req,
    output rv32i_frontend_pkg::rv32i_word imem_addr,
    input  logic                          imem_ack,
    input  rv32i_frontend_pkg::rv32i_word imem_rdata,
    input  logic                          ready,
    output logic                          push,
    output rv32i_frontend_pkg::rv32i_word push_inst,
    output rv32i_frontend_pkg::rv32i_word push_pc,
    output rv32i_frontend_pkg::rv32i_word push_pc_next,
    output logic                          push_pred,
    input  logic                          redirect_valid,
    input  rv32i_frontend_pkg::rv32i_word redirect_pc
);

    rv32i_frontend_pkg::fetch_state_e state;
    rv32i_frontend_pkg::rv32i_word    fetch_pc;     // address of the next request.
    logic                             discard;      // the request in flight is stale.
    logic                             capture;      // ack seen while waiting for it.
    logic                             keep;         // the captured word goes to the queue.
    logic [6:0]                       rdata_opc;
    logic                             is_jal;
    logic                             is_back_br;
    logic                             pred_taken;
    rv32i_frontend_pkg::rv32i_word    j_imm;
    rv32i_frontend_pkg::rv32i_word    b_imm;
    rv32i_frontend_pkg::rv32i_word    pred_target;

    assign capture = (state == rv32i_frontend_pkg::FETCH_WAIT_ACK) && imem_ack;
    assign keep    = !(discard || redirect_valid);  // a redirect in the capture cycle also drops it.

    // the predictor looks at the returned word directly.
    assign rdata_opc  = imem_rdata[6:0];
    assign j_imm      = {{12{imem_rdata[31]}}, imem_rdata[19:12], imem_rdata[20],
                         imem_rdata[30:21], 1'b0};
    assign b_imm      = {{20{imem_rdata[31]}}, imem_rdata[7], imem_rdata[30:25],
                         imem_rdata[11:8], 1'b0};
    assign is_jal     = (rdata_opc == 7'b1101111);
    assign is_back_br = (rdata_opc == 7'b1100011) && imem_rdata[31];  // sign bit means backward.
    assign pred_taken = is_jal || is_back_br;

    always_comb begin
        if (is_jal) begin
            pred_target = imem_addr + j_imm;
        end else if (is_back_br) begin
            pred_target = imem_addr + b_imm;
        end else begin
            pred_target = imem_addr + 32'd4;  // jalr and forward branches fall through.
        end
    end

    // imem_addr holds until the next request, so it is the pc of the pushed word.
    assign push_pc = imem_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= rv32i_frontend_pkg::FETCH_IDLE;
            imem_req  <= 1'b0;
            imem_addr <= `FRONTEND_RESET_PC;
            fetch_pc  <= `FRONTEND_RESET_PC;
            discard   <= 1'b0;
            push      <= 1'b0;
        end else begin
            push <= 1'b0;                     // push is a single-cycle pulse.
            if (redirect_valid) begin
                fetch_pc <= redirect_pc;      // restart at the new pc.
            end
            case (state)
                rv32i_frontend_pkg::FETCH_IDLE: begin
                    // a redirect in this cycle delays the request by one cycle.
                    if (!imem_ack && ready && !redirect_valid) begin
                        imem_req  <= 1'b1;
                        imem_addr <= fetch_pc;
                        discard   <= 1'b0;
                        state     <= rv32i_frontend_pkg::FETCH_WAIT_ACK;
                    end
                end
                rv32i_frontend_pkg::FETCH_WAIT_ACK: begin
                    if (redirect_valid) begin
                        discard <= 1'b1;      // finish the handshake but drop its data.
                    end
                    if (imem_ack) begin
                        imem_req <= 1'b0;
                        push     <= keep;
                        if (keep) begin
                            fetch_pc <= pred_target;  // follow the predicted path.
                        end
                        state <= rv32i_frontend_pkg::FETCH_WAIT_RELEASE;
                    end
                end
                rv32i_frontend_pkg::FETCH_WAIT_RELEASE: begin
                    if (!imem_ack) begin
                        state <= rv32i_frontend_pkg::FETCH_IDLE;
                    end
                end
                default: state <= rv32i_frontend_pkg::FETCH_IDLE;
            endcase
        end
    end

    // the captured word and its prediction wait here for the push cycle.
    always_ff @(posedge clk) begin
        if (capture) begin
            push_inst    <= imem_rdata;
            push_pc_next <= pred_target;
            push_pred    <= pred_taken;
        end
    end

endmodule

/* src/instruction_queue.sv */
`timescale 1ns/1ps
`include "rv32i_frontend_cfg.svh"

// shifting register queue between fetch and decode.
// new entries go in at index 0 and the oldest sits at head-1.
module instruction_queue #(
    parameter int num_entry = `FRONTEND_QUEUE_DEPTH
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,
    output logic                          ready,
    input  logic                          push,
    input  rv32i_frontend_pkg::rv32i_word push_inst,
    input  rv32i_frontend_pkg::rv32i_word push_pc,
    input  rv32i_frontend_pkg::rv32i_word push_pc_next,
    input  logic                          push_pred,
    input  logic                          pop,
    output logic                          valid_out,
    output rv32i_frontend_pkg::rv32i_word inst_out,
    output rv32i_frontend_pkg::rv32i_word pc_out,
    output rv32i_frontend_pkg::rv32i_word pc_next_out,
    output logic                          pred_out
);

    localparam int entry_w = 97;                     // pc_next, pc, pred and inst.
    localparam int head_w  = $clog2(num_entry + 1);

    logic [entry_w-1:0] regs [num_entry];
    logic [entry_w-1:0] data_in;
    logic [entry_w-1:0] head_entry;
    logic [head_w-1:0]  head;                        // number of valid entries.
    logic [head_w-1:0]  rd_idx;
    logic               push_ok;
    logic               pop_ok;

    assign data_in   = {push_pc_next, push_pc, push_pred, push_inst};
    assign ready     = (head < head_w'(num_entry));
    assign valid_out = (head != '0);
    assign push_ok   = push && ready;                // a push into a full queue is dropped.
    assign pop_ok    = pop && valid_out;
    assign rd_idx    = head - 1'b1;

    // head fields come straight from storage and read zero when empty.
    assign head_entry  = valid_out ? regs[rd_idx] : '0;
    assign inst_out    = head_entry[31:0];
    assign pred_out    = head_entry[32];
    assign pc_out      = head_entry[64:33];
    assign pc_next_out = head_entry[96:65];

    // every push moves all entries one place up.
    always_ff @(posedge clk) begin
        if (push_ok) begin
            regs[0] <= data_in;
            for (int i = 1; i < num_entry; i++) begin
                regs[i] <= regs[i-1];
            end
        end
    end

    // a push together with a pop leaves the count as it is.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
        end else if (flush) begin
            head <= '0;                              // storage stays, nothing is visible.
        end else if (push_ok && !pop_ok) begin
            head <= head + 1'b1;
        end else if (pop_ok && !push_ok) begin
            head <= head - 1'b1;
        end
    end

endmodule

/* src/rv32i_frontend.sv */
`timescale 1ns/1ps

// front end top level with fetch, queue and decode in a row.
module rv32i_frontend (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic                          imem_req,
    output rv32i_frontend_pkg::rv32i_word imem_addr,
    input  logic                          imem_ack,
    input  rv32i_frontend_pkg::rv32i_word imem_rdata,
    input  logic                          redirect_valid,
    input  rv32i_frontend_pkg::rv32i_word redirect_pc,
    output logic                          dec_req,
    input  logic                          dec_ack,
    output rv32i_frontend_pkg::rv32i_word dec_pc,
    output rv32i_frontend_pkg::rv32i_word dec_pc_next,
    output logic                          dec_pred,
    output rv32i_frontend_pkg::opcode_e   dec_opcode,
    output logic [4:0]                    dec_rd,
    output logic [4:0]                    dec_rs1,
    output logic [4:0]                    dec_rs2,
    output rv32i_frontend_pkg::rv32i_word dec_imm
);

    logic                          ready;
    logic                          push;
    rv32i_frontend_pkg::rv32i_word push_inst;
    rv32i_frontend_pkg::rv32i_word push_pc;
    rv32i_frontend_pkg::rv32i_word push_pc_next;
    logic                          push_pred;
    logic                          pop;
    logic                          valid_out;
    rv32i_frontend_pkg::rv32i_word inst_out;
    rv32i_frontend_pkg::rv32i_word pc_out;
    rv32i_frontend_pkg::rv32i_word pc_next_out;
    logic                          pred_out;

    fetch_unit fetch_unit_i (
        .clk, .rst_n, .imem_req, .imem_addr, .imem_ack, .imem_rdata,
        .ready, .push, .push_inst, .push_pc, .push_pc_next, .push_pred,
        .redirect_valid, .redirect_pc
    );

    // a redirect empties the queue in the same cycle.
    instruction_queue instruction_queue_i (
        .clk, .rst_n, .flush(redirect_valid), .ready,
        .push, .push_inst, .push_pc, .push_pc_next, .push_pred,
        .pop, .valid_out, .inst_out, .pc_out, .pc_next_out, .pred_out
    );

    decode_stage decode_stage_i (
        .clk, .rst_n, .valid_out, .inst_out, .pc_out, .pc_next_out, .pred_out,
        .pop, .dec_req, .dec_ack, .dec_pc, .dec_pc_next, .dec_pred,
        .dec_opcode, .dec_rd, .dec_rs1, .dec_rs2, .dec_imm
    );

endmodule

/* src/rv32i_frontend_cfg.svh */
`ifndef RV32I_FRONTEND_CFG_SVH
`define RV32I_FRONTEND_CFG_SVH

// number of entries in the instruction queue.
`define FRONTEND_QUEUE_DEPTH 6

// address of the first fetch after reset.
`define FRONTEND_RESET_PC 32'h0000_0000

`endif

/* src/rv32i_frontend_pkg.sv */
// shared types of the instruction front end.
package rv32i_frontend_pkg;

    // one word carries an instruction, a pc or an immediate.
    typedef logic [31:0] rv32i_word;

    // decoded instruction classes that are handed to the back end.
    typedef enum logic [3:0] {
        OP_LUI     = 4'd0,
        OP_AUIPC   = 4'd1,
        OP_JAL     = 4'd2,
        OP_JALR    = 4'd3,
        OP_BRANCH  = 4'd4,
        OP_LOAD    = 4'd5,
        OP_STORE   = 4'd6,
        OP_IMM     = 4'd7,
        OP_REG     = 4'd8,
        OP_FENCE   = 4'd9,
        OP_SYSTEM  = 4'd10,
        OP_ILLEGAL = 4'd15  // any opcode that is not listed above.
    } opcode_e;

    // states of the instruction memory handshake.
    typedef enum logic [1:0] {
        FETCH_IDLE,         // no request out.
        FETCH_WAIT_ACK,     // imem_req is high and waits for imem_ack.
        FETCH_WAIT_RELEASE  // imem_req is low and waits for imem_ack to fall.
    } fetch_state_e;

    // states of the back-end handshake.
    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_WAIT_ACK,
        DEC_WAIT_RELEASE
    } decode_state_e;

endpackage
